// ==== files.f ====
+incdir+include
hdl/stap_pkg.sv
hdl/stap_tms_cond.sv
hdl/stap_state_machine.sv
hdl/stap_wtap_ctrl.sv
hdl/stap_top.sv
testbench/stap_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the TAP controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module stap_tb -Mdir "$build_dir" -o stap_sim -f files.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$build_dir/stap_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Result: PASSED" "$log_file"; then
   exit 0
else
   echo "Pass message not found in $log_file"
   exit 1
fi

// ==== include/stap_tb_tasks.svh ====
/* TAP controller reference model, compare tasks and directed tests */
`ifndef STAP_TB_TASKS_SVH
`define STAP_TB_TASKS_SVH

// ****************************************
// Reference model
// ****************************************

tap_state_u            mdl_state;
logic [TMS_HIST_W-1:0] mdl_hist;
logic                  mdl_selectwir;
// Values held by the falling edge registers
logic                  mdl_capturewr;
logic                  mdl_shiftwr;
int                    soft_reset_seen;
// Result counts
int                    check_count;
int                    error_count;
int                    tests_run;
int                    tests_failed;

// IEEE 1149.1 transition table
function automatic logic [TAP_STATE_W-1:0] next_tap_state(
   input logic [TAP_STATE_W-1:0] cur, input logic tms);
   logic [TAP_STATE_W-1:0] nxt;
   case (cur)
      TLRS: nxt = tms ? TLRS : RUTI;
      RUTI: nxt = tms ? SDRS : RUTI;
      SDRS: nxt = tms ? SIRS : CADR;
      CADR: nxt = tms ? E1DR : SHDR;
      SHDR: nxt = tms ? E1DR : SHDR;
      E1DR: nxt = tms ? UPDR : PADR;
      PADR: nxt = tms ? E2DR : PADR;
      E2DR: nxt = tms ? UPDR : SHDR;
      UPDR: nxt = tms ? SDRS : RUTI;
      SIRS: nxt = tms ? TLRS : CAIR;
      CAIR: nxt = tms ? E1IR : SHIR;
      SHIR: nxt = tms ? E1IR : SHIR;
      E1IR: nxt = tms ? UPIR : PAIR;
      PAIR: nxt = tms ? E2IR : PAIR;
      E2IR: nxt = tms ? UPIR : SHIR;
      UPIR: nxt = tms ? SDRS : RUTI;
      default: nxt = TLRS;
   endcase
   return nxt;
endfunction

// Fifth effective one in a row outside TLRS
function automatic logic soft_reset_due(input logic tms_e);
   return (&mdl_hist) & tms_e & ~mdl_state.flag.tlrs;
endfunction

task model_reset();
   mdl_state.word = TLRS;
   mdl_hist       = '0;
   mdl_selectwir  = 1'b0;
   mdl_capturewr  = 1'b0;
   mdl_shiftwr    = 1'b0;
endtask

// Capture and shift follow the present state at the falling edge
task model_negedge(input logic tms_e);
   if (soft_reset_due(tms_e))
   begin
      mdl_capturewr = 1'b0;
      mdl_shiftwr   = 1'b0;
   end
   else
   begin
      mdl_capturewr = mdl_state.flag.cair | mdl_state.flag.cadr;
      mdl_shiftwr   = mdl_state.flag.shir | mdl_state.flag.shdr;
   end
endtask

// State, selectwir and TMS history at the rising edge
task model_posedge(input logic tms_e);
   tap_state_u nxt;
   logic       sr;
   sr = soft_reset_due(tms_e);
   if (sr)
   begin
      nxt.word = TLRS;
      soft_reset_seen++;
   end
   else
   begin
      nxt.word = next_tap_state(mdl_state.word, tms_e);
   end
   // Clear beats set and set beats hold
   if (mdl_state.flag.tlrs | mdl_state.flag.ruti)
      mdl_selectwir = 1'b0;
   else if (nxt.flag.tlrs | nxt.flag.cadr)
      mdl_selectwir = 1'b0;
   else if (nxt.flag.sirs)
      mdl_selectwir = 1'b1;
   // History flushed while in TLRS
   if (mdl_state.flag.tlrs)
      mdl_hist = '0;
   else
      mdl_hist = {mdl_hist[TMS_HIST_W-2:0], tms_e};
   mdl_state = nxt;
endtask

// ****************************************
// Compare tasks
// ****************************************

task compare_ctrl(input string name, input logic exp_val, input logic got_val);
   check_count++;
   if (got_val !== exp_val)
   begin
      error_count++;
      $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp_val, got_val);
   end
endtask

// States with no strobe of their own show as an all-zero word
task compare_state(input tap_state_u exp_state);
   tap_state_u             got_state;
   logic [TAP_STATE_W-1:0] shown;
   got_state.word      = '0;
   got_state.flag.tlrs = stap_fsm_tlrs;
   got_state.flag.ruti = stap_fsm_rti;
   got_state.flag.e1dr = stap_fsm_e1dr;
   got_state.flag.e2dr = stap_fsm_e2dr;
   got_state.flag.cair = stap_fsm_capture_ir;
   got_state.flag.shir = stap_fsm_shift_ir;
   got_state.flag.upir = stap_fsm_update_ir;
   got_state.flag.cadr = stap_fsm_capture_dr;
   got_state.flag.shdr = stap_fsm_shift_dr;
   got_state.flag.updr = stap_fsm_update_dr;
   shown = exp_state.word & (TLRS | RUTI | E1DR | E2DR | CAIR | SHIR | UPIR |
                             CADR | SHDR | UPDR);
   check_count++;
   if (got_state.word !== shown)
   begin
      error_count++;
      $display("Mismatch at %0t ns: state strobes expected %h got %h",
               $time, shown, got_state.word);
   end
endtask

// Everything the model predicts for the present state
task check_outputs();
   compare_state(mdl_state);
   compare_ctrl("stap_selectwir", mdl_selectwir, stap_selectwir);
   compare_ctrl("sn_fwtap_capturewr", mdl_capturewr, sn_fwtap_capturewr);
   compare_ctrl("sn_fwtap_shiftwr", mdl_shiftwr, sn_fwtap_shiftwr);
   compare_ctrl("sn_fwtap_updatewr", mdl_state.flag.upir | mdl_state.flag.updr,
                sn_fwtap_updatewr);
   compare_ctrl("sn_fwtap_rti", mdl_state.flag.ruti, sn_fwtap_rti);
   compare_ctrl("sn_fwtap_wrst_b", ~mdl_state.flag.tlrs, sn_fwtap_wrst_b);
endtask

// ****************************************
// Clock cycle driver
// ****************************************

// Entered 10 ns after a rising edge and left 10 ns after the next one
task tck_cycle(input logic tms, input logic remove);
   logic tms_e;
   tms_e = remove | tms;
   // Re-timed controls still show the last state before the falling edge
   compare_ctrl("sn_fwtap_capturewr", mdl_capturewr, sn_fwtap_capturewr);
   compare_ctrl("sn_fwtap_shiftwr", mdl_shiftwr, sn_fwtap_shiftwr);
   ftap_tms    = tms;
   tapc_remove = remove;
   #50;
   model_negedge(tms_e);
   check_outputs();
   @(posedge ftap_tck);
   model_posedge(tms_e);
   #10;
endtask

// One walk step checked against the walk's own expected state
task walk_step(input logic tms, input logic [TAP_STATE_W-1:0] exp_word);
   tap_state_u exp_state;
   exp_state.word = exp_word;
   tck_cycle(tms, 1'b0);
   compare_state(exp_state);
   check_count++;
   if (mdl_state.word !== exp_word)
   begin
      error_count++;
      $display("Reference model left the expected walk at %0t ns", $time);
   end
endtask

task report_test(input string name, input int errors_before);
   tests_run++;
   if (error_count == errors_before)
      $display("Test %s: ok", name);
   else
   begin
      tests_failed++;
      $display("Test %s: %0d errors", name, error_count - errors_before);
   end
endtask

// ****************************************
// Directed tests
// ****************************************

task test_reset_state();
   tap_state_u rst_state;
   int         errs;
   errs           = error_count;
   rst_state.word = TLRS;
   compare_state(rst_state);
   compare_ctrl("sn_fwtap_wrst_b", 1'b0, sn_fwtap_wrst_b);
   compare_ctrl("sn_fwtap_capturewr", 1'b0, sn_fwtap_capturewr);
   compare_ctrl("sn_fwtap_shiftwr", 1'b0, sn_fwtap_shiftwr);
   compare_ctrl("sn_fwtap_updatewr", 1'b0, sn_fwtap_updatewr);
   compare_ctrl("sn_fwtap_rti", 1'b0, sn_fwtap_rti);
   compare_ctrl("stap_selectwir", 1'b0, stap_selectwir);
   // TMS high keeps it parked
   repeat (3) walk_step(1'b1, TLRS);
   report_test("reset_state", errs);
endtask

task test_data_walk();
   int errs;
   errs = error_count;
   walk_step(1'b0, RUTI);
   walk_step(1'b1, SDRS);
   walk_step(1'b0, CADR);
   // Capture not yet re-timed
   compare_ctrl("sn_fwtap_capturewr", 1'b0, sn_fwtap_capturewr);
   walk_step(1'b0, SHDR);
   compare_ctrl("sn_fwtap_capturewr", 1'b1, sn_fwtap_capturewr);
   compare_ctrl("sn_fwtap_shiftwr", 1'b0, sn_fwtap_shiftwr);
   walk_step(1'b1, E1DR);
   compare_ctrl("sn_fwtap_shiftwr", 1'b1, sn_fwtap_shiftwr);
   walk_step(1'b0, PADR);
   walk_step(1'b1, E2DR);
   walk_step(1'b0, SHDR);
   walk_step(1'b1, E1DR);
   walk_step(1'b1, UPDR);
   walk_step(1'b0, RUTI);
   report_test("data_walk", errs);
endtask

task test_ir_walk();
   int errs;
   errs = error_count;
   walk_step(1'b1, SDRS);
   walk_step(1'b1, SIRS);
   compare_ctrl("stap_selectwir", 1'b1, stap_selectwir);
   walk_step(1'b0, CAIR);
   walk_step(1'b0, SHIR);
   walk_step(1'b0, SHIR);
   walk_step(1'b1, E1IR);
   walk_step(1'b0, PAIR);
   walk_step(1'b1, E2IR);
   walk_step(1'b1, UPIR);
   compare_ctrl("stap_selectwir", 1'b1, stap_selectwir);
   walk_step(1'b1, SDRS);
   compare_ctrl("stap_selectwir", 1'b1, stap_selectwir);
   // DR scan drops the IR flag
   walk_step(1'b0, CADR);
   compare_ctrl("stap_selectwir", 1'b0, stap_selectwir);
   walk_step(1'b1, E1DR);
   walk_step(1'b1, UPDR);
   walk_step(1'b0, RUTI);
   report_test("ir_walk", errs);
endtask

task test_remove();
   logic [31:0] rnd;
   int          edges;
   int          errs;
   errs = error_count;
   // Park deep in the IR column first
   walk_step(1'b1, SDRS);
   walk_step(1'b1, SIRS);
   walk_step(1'b0, CAIR);
   walk_step(1'b0, SHIR);
   edges = 0;
   while (!stap_fsm_tlrs && edges < SOFT_RESET_COUNT)
   begin
      rnd = $urandom;
      tck_cycle(rnd[0], 1'b1);
      edges++;
   end
   if (!stap_fsm_tlrs)
   begin
      error_count++;
      $display("Controller not in Test-Logic-Reset after %0d edges with tapc_remove high",
               edges);
   end
   // TMS ignored while removed
   repeat (4)
   begin
      rnd = $urandom;
      tck_cycle(rnd[0], 1'b1);
      compare_ctrl("stap_fsm_tlrs", 1'b1, stap_fsm_tlrs);
   end
   walk_step(1'b0, RUTI);
   report_test("remove", errs);
endtask

task test_random_tms();
   logic [31:0] rnd;
   int          errs;
   int          sr_before;
   errs      = error_count;
   sr_before = soft_reset_seen;
   // TMS biased towards one so soft resets happen
   repeat (1000)
   begin
      rnd = $urandom;
      tck_cycle(rnd[2:0] < 3'd5, rnd[7:4] == 4'hf);
   end
   $display("Random run saw %0d soft resets", soft_reset_seen - sr_before);
   if (soft_reset_seen == sr_before)
   begin
      error_count++;
      $display("Random run produced no soft reset");
   end
   report_test("random_tms", errs);
endtask

`endif

// ==== testbench/stap_tb.sv ====
/* TAP controller testbench with clock, reset, DUT and directed test sequence */
`timescale 1ns/1ns

module stap_tb
   import stap_pkg::*;
   ();

   // DUT inputs
   logic ftap_tck;
   logic powergood_rst_trst_b;
   logic ftap_tms;
   logic tapc_remove;
   // State strobes
   logic stap_fsm_tlrs;
   logic stap_fsm_rti;
   logic stap_fsm_e1dr;
   logic stap_fsm_e2dr;
   logic stap_fsm_capture_ir;
   logic stap_fsm_shift_ir;
   logic stap_fsm_update_ir;
   logic stap_fsm_capture_dr;
   logic stap_fsm_shift_dr;
   logic stap_fsm_update_dr;
   logic stap_selectwir;
   // Wrapper controls
   logic sn_fwtap_capturewr;
   logic sn_fwtap_shiftwr;
   logic sn_fwtap_updatewr;
   logic sn_fwtap_rti;
   logic sn_fwtap_wrst_b;
   int   seed_ret;

`include "stap_tb_tasks.svh"

   stap_top dut (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tms             (ftap_tms),
      .tapc_remove          (tapc_remove),
      .stap_fsm_tlrs        (stap_fsm_tlrs),
      .stap_fsm_rti         (stap_fsm_rti),
      .stap_fsm_e1dr        (stap_fsm_e1dr),
      .stap_fsm_e2dr        (stap_fsm_e2dr),
      .stap_fsm_capture_ir  (stap_fsm_capture_ir),
      .stap_fsm_shift_ir    (stap_fsm_shift_ir),
      .stap_fsm_update_ir   (stap_fsm_update_ir),
      .stap_fsm_capture_dr  (stap_fsm_capture_dr),
      .stap_fsm_shift_dr    (stap_fsm_shift_dr),
      .stap_fsm_update_dr   (stap_fsm_update_dr),
      .stap_selectwir       (stap_selectwir),
      .sn_fwtap_capturewr   (sn_fwtap_capturewr),
      .sn_fwtap_shiftwr     (sn_fwtap_shiftwr),
      .sn_fwtap_updatewr    (sn_fwtap_updatewr),
      .sn_fwtap_rti         (sn_fwtap_rti),
      .sn_fwtap_wrst_b      (sn_fwtap_wrst_b)
   );

   // ****************************************
   // Clock and run limit
   // ****************************************

   // 100 ns period
   initial
   begin
      ftap_tck = 1'b0;
      forever #50 ftap_tck = ~ftap_tck;
   end

   // Whole run is far below this
   initial
   begin
      #500000;
      $display("Simulation time limit reached before the tests completed");
      $display("Result: FAILED");
      $finish;
   end

   // ****************************************
   // Test sequence
   // ****************************************

   initial
   begin
      ftap_tms             = 1'b0;
      tapc_remove          = 1'b0;
      powergood_rst_trst_b = 1'b0;
      check_count          = 0;
      error_count          = 0;
      tests_run            = 0;
      tests_failed         = 0;
      soft_reset_seen      = 0;
      seed_ret             = $urandom(32'h4ad3d522);
      model_reset();
      // Reset held for five clocks, released off the edge
      repeat (5) @(posedge ftap_tck);
      #10;
      powergood_rst_trst_b = 1'b1;

      test_reset_state();
      test_data_walk();
      test_ir_walk();
      test_remove();
      test_random_tms();

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== hdl/stap_top.sv ====
/* TAP controller top with TMS conditioner, state machine
   and wrapper TAP controls */
`timescale 1ns/1ns

module stap_top
   import stap_pkg::*;
   (
   input  logic ftap_tck,
   input  logic powergood_rst_trst_b,
   input  logic ftap_tms,
   input  logic tapc_remove,
   // State strobes
   output logic stap_fsm_tlrs,
   output logic stap_fsm_rti,
   output logic stap_fsm_e1dr,
   output logic stap_fsm_e2dr,
   output logic stap_fsm_capture_ir,
   output logic stap_fsm_shift_ir,
   output logic stap_fsm_update_ir,
   output logic stap_fsm_capture_dr,
   output logic stap_fsm_shift_dr,
   output logic stap_fsm_update_dr,
   output logic stap_selectwir,
   // Wrapper TAP controls
   output logic sn_fwtap_capturewr,
   output logic sn_fwtap_shiftwr,
   output logic sn_fwtap_updatewr,
   output logic sn_fwtap_rti,
   output logic sn_fwtap_wrst_b
   );

   // Conditioned TMS and its soft reset
   logic       tms_eff;
   logic       soft_reset;
   // Present state, kept inside the top
   tap_state_u state;

   // ****************************************
   // TMS conditioner
   // ****************************************
   stap_tms_cond i_tms_cond (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .ftap_tms             (ftap_tms),
      .tapc_remove          (tapc_remove),
      .stap_fsm_tlrs        (stap_fsm_tlrs),
      .tms_eff              (tms_eff),
      .soft_reset           (soft_reset)
   );

   // ****************************************
   // TAP state machine
   // ****************************************
   stap_state_machine i_state_machine (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .tms_eff              (tms_eff),
      .soft_reset           (soft_reset),
      .state                (state),
      .stap_fsm_tlrs        (stap_fsm_tlrs),
      .stap_fsm_rti         (stap_fsm_rti),
      .stap_fsm_e1dr        (stap_fsm_e1dr),
      .stap_fsm_e2dr        (stap_fsm_e2dr),
      .stap_fsm_capture_ir  (stap_fsm_capture_ir),
      .stap_fsm_shift_ir    (stap_fsm_shift_ir),
      .stap_fsm_update_ir   (stap_fsm_update_ir),
      .stap_fsm_capture_dr  (stap_fsm_capture_dr),
      .stap_fsm_shift_dr    (stap_fsm_shift_dr),
      .stap_fsm_update_dr   (stap_fsm_update_dr),
      .stap_selectwir       (stap_selectwir)
   );

   // ****************************************
   // Wrapper TAP controls
   // ****************************************
   stap_wtap_ctrl i_wtap_ctrl (
      .ftap_tck             (ftap_tck),
      .powergood_rst_trst_b (powergood_rst_trst_b),
      .soft_reset           (soft_reset),
      .state                (state),
      .sn_fwtap_capturewr   (sn_fwtap_capturewr),
      .sn_fwtap_shiftwr     (sn_fwtap_shiftwr),
      .sn_fwtap_updatewr    (sn_fwtap_updatewr),
      .sn_fwtap_rti         (sn_fwtap_rti),
      .sn_fwtap_wrst_b      (sn_fwtap_wrst_b)
   );

endmodule

// ==== hdl/stap_wtap_ctrl.sv ====
/* Wrapper TAP control group shared by IR and DR paths,
   capture and shift re-timed on the falling clock edge */
`timescale 1ns/1ns

module stap_wtap_ctrl
   import stap_pkg::*;
   (
   input  logic       ftap_tck,
   input  logic       powergood_rst_trst_b,
   input  logic       soft_reset,
   input  tap_state_u state,
   output logic       sn_fwtap_capturewr,
   output logic       sn_fwtap_shiftwr,
   output logic       sn_fwtap_updatewr,
   output logic       sn_fwtap_rti,
   output logic       sn_fwtap_wrst_b
   );

   // Posedge-domain decodes ahead of re-timing
   logic capturewr_pos;
   logic shiftwr_pos;

   // ****************************************
   // State decodes
   // ****************************************

   // Either capture state, IR or DR
   assign capturewr_pos = state.flag.cair | state.flag.cadr;
   // Either shift state
   assign shiftwr_pos   = state.flag.shir | state.flag.shdr;

   // Update and idle go straight out
   assign sn_fwtap_updatewr = state.flag.upir | state.flag.updr;
   assign sn_fwtap_rti      = state.flag.ruti;

   // Wrapper held in reset while controller sits in TLRS
   assign sn_fwtap_wrst_b = ~state.flag.tlrs;

   // ****************************************
   // Falling edge re-timing
   // ****************************************

   // Half a cycle after state entry, gives wrapper setup margin
   always_ff @(negedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         sn_fwtap_capturewr <= CTRL_INACTIVE;
         sn_fwtap_shiftwr   <= CTRL_INACTIVE;
      end
      else if (soft_reset)
      begin
         sn_fwtap_capturewr <= CTRL_INACTIVE;
         sn_fwtap_shiftwr   <= CTRL_INACTIVE;
      end
      else
      begin
         sn_fwtap_capturewr <= capturewr_pos;
         sn_fwtap_shiftwr   <= shiftwr_pos;
      end
   end

   // Relies on the FSM word staying one-hot across both edges
   a_capture_shift_excl : assert property (
      @(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      !(sn_fwtap_capturewr && sn_fwtap_shiftwr))
      else $error("wrapper capture and shift both active");

endmodule

// ==== hdl/stap_state_machine.sv ====
/* TAP controller FSM with one-hot state register, next-state decode,
   per-state strobes and the instruction scan (selectwir) flag */
`timescale 1ns/1ns

module stap_state_machine
   import stap_pkg::*;
   (
   input  logic       ftap_tck,
   input  logic       powergood_rst_trst_b,
   input  logic       tms_eff,
   input  logic       soft_reset,
   output tap_state_u state,
   output logic       stap_fsm_tlrs,
   output logic       stap_fsm_rti,
   output logic       stap_fsm_e1dr,
   output logic       stap_fsm_e2dr,
   output logic       stap_fsm_capture_ir,
   output logic       stap_fsm_shift_ir,
   output logic       stap_fsm_update_ir,
   output logic       stap_fsm_capture_dr,
   output logic       stap_fsm_shift_dr,
   output logic       stap_fsm_update_dr,
   output logic       stap_selectwir
   );

   // One-hot present and next state
   tap_state_u state_ps;
   tap_state_u state_ns;

   // ****************************************
   // Next-state decode
   // ****************************************

   // IEEE 1149.1 transition table on the whole word
   always_comb
   begin
      case (state_ps.word)
         TLRS:
            state_ns.word = tms_eff ? TLRS : RUTI;
         RUTI:
            state_ns.word = tms_eff ? SDRS : RUTI;
         // Data column
         SDRS:
            state_ns.word = tms_eff ? SIRS : CADR;
         CADR:
            state_ns.word = tms_eff ? E1DR : SHDR;
         SHDR:
            state_ns.word = tms_eff ? E1DR : SHDR;
         E1DR:
            state_ns.word = tms_eff ? UPDR : PADR;
         PADR:
            state_ns.word = tms_eff ? E2DR : PADR;
         E2DR:
            state_ns.word = tms_eff ? UPDR : SHDR;
         UPDR:
            state_ns.word = tms_eff ? SDRS : RUTI;
         // Instruction column
         SIRS:
            state_ns.word = tms_eff ? TLRS : CAIR;
         CAIR:
            state_ns.word = tms_eff ? E1IR : SHIR;
         SHIR:
            state_ns.word = tms_eff ? E1IR : SHIR;
         E1IR:
            state_ns.word = tms_eff ? UPIR : PAIR;
         PAIR:
            state_ns.word = tms_eff ? E2IR : PAIR;
         E2IR:
            state_ns.word = tms_eff ? UPIR : SHIR;
         UPIR:
            state_ns.word = tms_eff ? SDRS : RUTI;
         // Illegal word recovers through reset state
         default:
            state_ns.word = TLRS;
      endcase

      // Soft reset wins over the table
      if (soft_reset)
      begin
         state_ns.word = TLRS;
      end
   end

   // ****************************************
   // State register
   // ****************************************

   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         state_ps.word <= TAP_STATE_RESET;
      end
      else
      begin
         state_ps.word <= state_ns.word;
      end
   end

   // Wrapper controls decode the same word
   assign state = state_ps;

   // ****************************************
   // Per-state strobes
   // ****************************************

   assign stap_fsm_tlrs       = state_ps.flag.tlrs;
   assign stap_fsm_rti        = state_ps.flag.ruti;
   assign stap_fsm_e1dr       = state_ps.flag.e1dr;
   assign stap_fsm_e2dr       = state_ps.flag.e2dr;
   // IR scan strobes
   assign stap_fsm_capture_ir = state_ps.flag.cair;
   assign stap_fsm_shift_ir   = state_ps.flag.shir;
   assign stap_fsm_update_ir  = state_ps.flag.upir;
   // DR scan strobes
   assign stap_fsm_capture_dr = state_ps.flag.cadr;
   assign stap_fsm_shift_dr   = state_ps.flag.shdr;
   assign stap_fsm_update_dr  = state_ps.flag.updr;

   // ****************************************
   // Instruction scan flag
   // ****************************************

   // Set entering SIRS and held through the IR column back to SDRS
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         stap_selectwir <= CTRL_INACTIVE;
      end
      else if (state_ps.flag.tlrs | state_ps.flag.ruti)
      begin
         stap_selectwir <= CTRL_INACTIVE;
      end
      else if (state_ns.flag.tlrs | state_ns.flag.cadr)
      begin
         // Leaving for reset or a DR scan
         stap_selectwir <= CTRL_INACTIVE;
      end
      else if (state_ns.flag.sirs)
      begin
         stap_selectwir <= 1'b1;
      end
   end

   // Exactly one state bit at all times
   a_state_onehot : assert property (
      @(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      $onehot(state_ps.word))
      else $error("state word not one-hot");

   // IR flag seen in RUTI only on the cycle right after Update-IR
   a_selectwir_low_rti : assert property (
      @(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      (stap_fsm_rti && stap_selectwir) |-> $past(stap_fsm_update_ir))
      else $error("selectwir high in Run-Test/Idle without a preceding Update-IR");

endmodule

// ==== hdl/stap_tms_cond.sv ====
/* TMS conditioner with controller remove override and
   five consecutive ones soft reset detect */
`timescale 1ns/1ns

module stap_tms_cond
   import stap_pkg::*;
   (
   input  logic ftap_tck,
   input  logic powergood_rst_trst_b,
   input  logic ftap_tms,
   input  logic tapc_remove,
   input  logic stap_fsm_tlrs,
   output logic tms_eff,
   output logic soft_reset
   );

   // Previous effective TMS samples with the newest in bit 0
   logic [TMS_HIST_W-1:0] tms_hist;

   // ****************************************
   // Effective TMS
   // ****************************************

   // Removed controller sees TMS held at one
   assign tms_eff = tapc_remove | ftap_tms;

   // ****************************************
   // Soft reset detect
   // ****************************************

   // Shift history flushed while parked in TLRS
   always_ff @(posedge ftap_tck or negedge powergood_rst_trst_b)
   begin
      if (!powergood_rst_trst_b)
      begin
         tms_hist <= {TMS_HIST_W{CTRL_INACTIVE}};
      end
      else if (stap_fsm_tlrs)
      begin
         tms_hist <= {TMS_HIST_W{CTRL_INACTIVE}};
      end
      else
      begin
         tms_hist <= {tms_hist[TMS_HIST_W-2:0], tms_eff};
      end
   end

   // Fifth one in a row outside TLRS
   // History may still be full on the first TLRS cycle
   assign soft_reset = (&tms_hist) & tms_eff & ~stap_fsm_tlrs;

   // Controller lands in TLRS one edge later
   a_soft_reset_lands_tlrs : assert property (
      @(posedge ftap_tck) disable iff (!powergood_rst_trst_b)
      soft_reset |=> stap_fsm_tlrs)
      else $error("soft reset did not reach Test-Logic-Reset");

endmodule

// ==== hdl/stap_pkg.sv ====
/* TAP controller package with one-hot state encodings, the state word union,
   soft reset count and control reset values */
package stap_pkg;

   // ****************************************
   // State encoding
   // ****************************************

   // One-hot state word width
   localparam int TAP_STATE_W = 16;

   // Data register column
   localparam logic [TAP_STATE_W-1:0] TLRS = 16'h0001;
   localparam logic [TAP_STATE_W-1:0] RUTI = 16'h0002;
   localparam logic [TAP_STATE_W-1:0] SDRS = 16'h0004;
   localparam logic [TAP_STATE_W-1:0] CADR = 16'h0008;
   localparam logic [TAP_STATE_W-1:0] SHDR = 16'h0010;
   localparam logic [TAP_STATE_W-1:0] E1DR = 16'h0020;
   localparam logic [TAP_STATE_W-1:0] PADR = 16'h0040;
   localparam logic [TAP_STATE_W-1:0] E2DR = 16'h0080;
   localparam logic [TAP_STATE_W-1:0] UPDR = 16'h0100;
   // Instruction register column
   localparam logic [TAP_STATE_W-1:0] SIRS = 16'h0200;
   localparam logic [TAP_STATE_W-1:0] CAIR = 16'h0400;
   localparam logic [TAP_STATE_W-1:0] SHIR = 16'h0800;
   localparam logic [TAP_STATE_W-1:0] E1IR = 16'h1000;
   localparam logic [TAP_STATE_W-1:0] PAIR = 16'h2000;
   localparam logic [TAP_STATE_W-1:0] E2IR = 16'h4000;
   localparam logic [TAP_STATE_W-1:0] UPIR = 16'h8000;

   // Named flags, MSB first so each lines up with its one-hot bit
   typedef struct packed {
      logic upir;
      logic e2ir;
      logic pair;
      logic e1ir;
      logic shir;
      logic cair;
      logic sirs;
      logic updr;
      logic e2dr;
      logic padr;
      logic e1dr;
      logic shdr;
      logic cadr;
      logic sdrs;
      logic ruti;
      logic tlrs;
   } tap_state_flags_t;

   // Same state word, seen whole or as flags
   typedef union packed {
      logic [TAP_STATE_W-1:0] word;
      tap_state_flags_t       flag;
   } tap_state_u;

   // ****************************************
   // Soft reset and reset values
   // ****************************************

   // Consecutive effective TMS ones that force Test-Logic-Reset
   localparam int SOFT_RESET_COUNT = 5;
   // History holds all but the current sample
   localparam int TMS_HIST_W       = SOFT_RESET_COUNT - 1;

   // Inactive control level
   localparam logic CTRL_INACTIVE = 1'b0;
   // Controller comes out of reset here
   localparam logic [TAP_STATE_W-1:0] TAP_STATE_RESET = TLRS;

endpackage
